// File: rtl/cpu_defines.svh
// ------------------------------
// widths, watch address, opcodes and controller wait cycles
// NUM_WORDS must equal 2**ADDR_BITS
// ------------------------------
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

`define WORD_BITS  8
`define ADDR_BITS  5
`define NUM_WORDS  32
`define WATCH_ADDR 31

// upper 3 bits of an instruction word
`define OP_LDI   3'd0
`define OP_LOAD  3'd1
`define OP_ADD   3'd2
`define OP_SUB   3'd3
`define OP_STORE 3'd4
`define OP_JMP   3'd5
`define OP_JZ    3'd6
`define OP_HALT  3'd7

// extra controller cycles per access
`define READ_WAIT  1
`define WRITE_WAIT 1

`endif

// File: rtl/cpu_pkg.sv
// ------------------------------
// shared types of the boot-and-run subsystem
// ------------------------------
`include "cpu_defines.svh"

package cpu_pkg;

	// data and address words
	typedef logic [`WORD_BITS-1:0] word_t;
	typedef logic [`ADDR_BITS-1:0] addr_t;

	// opcode field, whatever is left above the operand
	typedef logic [`WORD_BITS-`ADDR_BITS-1:0] opcode_t;

	// cpu sequencing
	typedef enum logic [2:0] {
		FETCH,
		FETCH_WAIT,
		EXEC,
		MEM_WAIT,
		HALTED
	} cpu_state_t;

	// memory controller sequencing
	typedef enum logic [1:0] {
		IDLE,
		READ_WAIT,
		WRITE_PREP,
		WRITE_DO
	} ctrl_state_t;

endpackage

// File: rtl/mem_bus_if.sv
// ------------------------------
// cpu memory request bus, one access outstanding
// request held until ready, ready lasts one cycle
// ------------------------------
`timescale 1ns/1ps

interface mem_bus_if;

	// request side
	logic           valid;
	logic           write;
	cpu_pkg::addr_t addr;
	cpu_pkg::word_t wdata;

	// response side
	logic           ready;
	cpu_pkg::word_t rdata;

	modport cpu (
		output valid, write, addr, wdata,
		input  ready, rdata
	);

	modport ctrl (
		input  valid, write, addr, wdata,
		output ready, rdata
	);

endinterface

// File: rtl/boot_copy.sv
// ------------------------------
// copies the boot image into ram once per reset
// image read from rtl/program.hex, path relative to the run directory
// ------------------------------
`timescale 1ns/1ps
`include "cpu_defines.svh"

module boot_copy (
	input  logic           clock,
	input  logic           reset,
	output logic           copy_we,
	output cpu_pkg::addr_t copy_addr,
	output cpu_pkg::word_t copy_data,
	output logic           copy_done
);

	// boot image
	cpu_pkg::word_t image [`NUM_WORDS];

	initial begin
		$readmemh("rtl/program.hex", image);
	end

	// next word to copy, top bit set once all words are out
	logic [`ADDR_BITS:0] idx;

	always_ff @(posedge clock) begin
		if (reset) begin
			idx       <= '0;
			copy_we   <= 1'b0;
			copy_addr <= '0;
			copy_done <= 1'b0;
		end else if (idx < (`ADDR_BITS+1)'(`NUM_WORDS)) begin
			// one word per cycle
			copy_we   <= 1'b1;
			copy_addr <= idx[`ADDR_BITS-1:0];
			idx       <= idx + 1'b1;
		end else begin
			// done one cycle after the last write
			copy_we   <= 1'b0;
			copy_done <= copy_done | copy_we;
		end
	end

	// data follows the address register
	always_ff @(posedge clock) begin
		copy_data <= image[idx[`ADDR_BITS-1:0]];
	end

endmodule

// File: rtl/data_ram.sv
// ------------------------------
// single-port ram, registered read, contents not reset
// read returns the old word during a write
// ------------------------------
`timescale 1ns/1ps
`include "cpu_defines.svh"

module data_ram (
	input  logic           clock,
	input  logic           we,
	input  cpu_pkg::addr_t addr,
	input  cpu_pkg::word_t wdata,
	output cpu_pkg::word_t rdata
);

	cpu_pkg::word_t mem [`NUM_WORDS];

	always_ff @(posedge clock) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		// read data one cycle after the address
		rdata <= mem[addr];
	end

endmodule

// File: rtl/mem_ctrl.sv
// ------------------------------
// ram port owner: copier until copy_done, then the cpu
// read ready 2 cycles after accept, write ready 4 cycles after
// ------------------------------
`timescale 1ns/1ps
`include "cpu_defines.svh"

module mem_ctrl (
	input  logic           clock,
	input  logic           reset,
	mem_bus_if.ctrl        bus,
	input  logic           copy_we,
	input  cpu_pkg::addr_t copy_addr,
	input  cpu_pkg::word_t copy_data,
	input  logic           copy_done,
	output logic           ram_we,
	output cpu_pkg::addr_t ram_addr,
	output cpu_pkg::word_t ram_wdata,
	input  cpu_pkg::word_t ram_rdata,
	output cpu_pkg::word_t watch,
	output logic           watch_strobe
);

	cpu_pkg::ctrl_state_t state, state_next;
	// cycles spent in the current state
	logic [1:0] wait_cnt;
	// latched cpu write data
	cpu_pkg::word_t wdata_q;
	logic cpu_we;
	logic ready;

	// ------------------------------
	// cpu access sequencing
	// ------------------------------
	always_comb begin
		state_next = state;
		cpu_we     = 1'b0;
		ready      = 1'b0;
		case (state)
			cpu_pkg::IDLE: begin
				// no cpu traffic while the copier owns the port
				if (copy_done && bus.valid) begin
					state_next = bus.write ? cpu_pkg::WRITE_PREP : cpu_pkg::READ_WAIT;
				end
			end
			cpu_pkg::READ_WAIT: begin
				// ram data settles after the extra cycles
				if (wait_cnt == 2'(`READ_WAIT)) begin
					ready      = 1'b1;
					state_next = cpu_pkg::IDLE;
				end
			end
			cpu_pkg::WRITE_PREP: begin
				if (wait_cnt == 2'(`WRITE_WAIT - 1)) begin
					state_next = cpu_pkg::WRITE_DO;
				end
			end
			cpu_pkg::WRITE_DO: begin
				// single write cycle, then read it back
				cpu_we     = 1'b1;
				state_next = cpu_pkg::READ_WAIT;
			end
			default: begin
				state_next = cpu_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state    <= cpu_pkg::IDLE;
			wait_cnt <= '0;
		end else begin
			state    <= state_next;
			wait_cnt <= (state_next != state) ? 2'd0 : wait_cnt + 2'd1;
		end
	end

	// write data captured while preparing
	always_ff @(posedge clock) begin
		if (state == cpu_pkg::WRITE_PREP) begin
			wdata_q <= bus.wdata;
		end
	end

	// ------------------------------
	// ram port select
	// ------------------------------
	assign ram_we    = copy_done ? cpu_we  : copy_we;
	assign ram_addr  = copy_done ? bus.addr : copy_addr;
	assign ram_wdata = copy_done ? wdata_q : copy_data;

	assign bus.ready = ready;
	assign bus.rdata = ram_rdata;

	// watch word, copier writes count too
	always_ff @(posedge clock) begin
		if (reset) begin
			watch        <= '0;
			watch_strobe <= 1'b0;
		end else begin
			watch_strobe <= ram_we && (ram_addr == cpu_pkg::addr_t'(`WATCH_ADDR));
			if (ram_we && (ram_addr == cpu_pkg::addr_t'(`WATCH_ADDR))) begin
				watch <= ram_wdata;
			end
		end
	end

endmodule

// File: rtl/cpu8.sv
// ------------------------------
// multicycle accumulator cpu, eight opcodes, wrapping arithmetic
// non-memory instructions take 4 cycles including the fetch
// ------------------------------
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu8 (
	input  logic   clock,
	input  logic   reset,
	mem_bus_if.cpu bus,
	output logic   halted
);

	cpu_pkg::cpu_state_t state;
	cpu_pkg::addr_t pc;
	cpu_pkg::addr_t pc_next;
	cpu_pkg::word_t acc;
	cpu_pkg::word_t ir;
	cpu_pkg::opcode_t opcode;
	cpu_pkg::addr_t operand;

	// bus request registers
	logic           mem_valid;
	logic           mem_write;
	cpu_pkg::addr_t mem_addr;
	cpu_pkg::word_t mem_wdata;

	// instruction fields
	assign opcode  = ir[`WORD_BITS-1:`ADDR_BITS];
	assign operand = ir[`ADDR_BITS-1:0];

	// jumps take the operand, everything else steps
	always_comb begin
		pc_next = pc + 1'b1;
		if (opcode == `OP_JMP || (opcode == `OP_JZ && acc == '0)) begin
			pc_next = operand;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= cpu_pkg::FETCH;
			pc        <= '0;
			acc       <= '0;
			mem_valid <= 1'b0;
			mem_write <= 1'b0;
			mem_addr  <= '0;
		end else begin
			case (state)
				cpu_pkg::FETCH: begin
					mem_valid <= 1'b1;
					mem_write <= 1'b0;
					mem_addr  <= pc;
					state     <= cpu_pkg::FETCH_WAIT;
				end
				cpu_pkg::FETCH_WAIT: begin
					// stall until the controller answers
					if (bus.ready) begin
						mem_valid <= 1'b0;
						state     <= cpu_pkg::EXEC;
					end
				end
				cpu_pkg::EXEC: begin
					case (opcode)
						`OP_HALT: begin
							state <= cpu_pkg::HALTED;
						end
						`OP_LOAD, `OP_ADD, `OP_SUB, `OP_STORE: begin
							mem_valid <= 1'b1;
							mem_write <= (opcode == `OP_STORE);
							mem_addr  <= operand;
							pc        <= pc_next;
							state     <= cpu_pkg::MEM_WAIT;
						end
						default: begin
							// ldi, jmp, jz: next fetch starts right away
							if (opcode == `OP_LDI) begin
								acc <= cpu_pkg::word_t'(operand);
							end
							mem_valid <= 1'b1;
							mem_write <= 1'b0;
							mem_addr  <= pc_next;
							pc        <= pc_next;
							state     <= cpu_pkg::FETCH_WAIT;
						end
					endcase
				end
				cpu_pkg::MEM_WAIT: begin
					if (bus.ready) begin
						mem_valid <= 1'b0;
						mem_write <= 1'b0;
						case (opcode)
							`OP_LOAD: acc <= bus.rdata;
							`OP_ADD:  acc <= acc + bus.rdata;
							`OP_SUB:  acc <= acc - bus.rdata;
							default: ;
						endcase
						state <= cpu_pkg::FETCH;
					end
				end
				default: begin
					// halted until reset
					state <= cpu_pkg::HALTED;
				end
			endcase
		end
	end

	// instruction register and store data
	always_ff @(posedge clock) begin
		if (state == cpu_pkg::FETCH_WAIT && bus.ready) begin
			ir <= bus.rdata;
		end
		if (state == cpu_pkg::EXEC) begin
			mem_wdata <= acc;
		end
	end

	assign bus.valid = mem_valid;
	assign bus.write = mem_write;
	assign bus.addr  = mem_addr;
	assign bus.wdata = mem_wdata;

	assign halted = (state == cpu_pkg::HALTED);

endmodule

// File: rtl/cpu_system.sv
// ------------------------------
// boot copy, ram, controller and cpu under one top
// cpu held in reset until the boot copy is done
// ------------------------------
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_system (
	input  logic                  clock,
	input  logic                  reset,
	output logic [`WORD_BITS-1:0] watch,
	output logic                  watch_strobe,
	output logic                  running,
	output logic                  halted
);

	// copier to controller
	logic           copy_we;
	cpu_pkg::addr_t copy_addr;
	cpu_pkg::word_t copy_data;
	logic           copy_done;

	// controller to ram
	logic           ram_we;
	cpu_pkg::addr_t ram_addr;
	cpu_pkg::word_t ram_wdata;
	cpu_pkg::word_t ram_rdata;

	logic cpu_reset;

	mem_bus_if bus ();

	// cpu runs only once the image is in ram
	assign cpu_reset = reset | ~copy_done;
	assign running   = copy_done;

	boot_copy i_boot_copy (
		.clock     (clock),
		.reset     (reset),
		.copy_we   (copy_we),
		.copy_addr (copy_addr),
		.copy_data (copy_data),
		.copy_done (copy_done)
	);

	data_ram i_data_ram (
		.clock (clock),
		.we    (ram_we),
		.addr  (ram_addr),
		.wdata (ram_wdata),
		.rdata (ram_rdata)
	);

	mem_ctrl i_mem_ctrl (
		.clock        (clock),
		.reset        (reset),
		.bus          (bus.ctrl),
		.copy_we      (copy_we),
		.copy_addr    (copy_addr),
		.copy_data    (copy_data),
		.copy_done    (copy_done),
		.ram_we       (ram_we),
		.ram_addr     (ram_addr),
		.ram_wdata    (ram_wdata),
		.ram_rdata    (ram_rdata),
		.watch        (watch),
		.watch_strobe (watch_strobe)
	);

	cpu8 i_cpu8 (
		.clock  (clock),
		.reset  (cpu_reset),
		.bus    (bus.cpu),
		.halted (halted)
	);

endmodule

// File: test/cpu_system_chk.sv
// ------------------------------
// bus, boot and output rules of cpu_system
// all checks off while reset is high
// ------------------------------
`timescale 1ns/1ps

module cpu_system_chk (
	input logic clock,
	input logic reset,
	input logic valid,
	input logic ready,
	input logic copy_done,
	input logic watch_strobe,
	input logic halted
);

	// controller answers only a pending request
	a_ready_needs_valid: assert property (@(posedge clock) disable iff (reset)
		ready |-> valid)
		else $error("ready high without a valid request");

	// cpu stays off the bus until the image is in ram
	a_no_cpu_write_in_boot: assert property (@(posedge clock) disable iff (reset)
		!copy_done |-> !valid)
		else $error("cpu memory request before copy_done");

	a_strobe_one_cycle: assert property (@(posedge clock) disable iff (reset)
		watch_strobe |=> !watch_strobe)
		else $error("watch_strobe longer than one cycle");

	// sticky until reset
	a_halted_stays: assert property (@(posedge clock) disable iff (reset)
		halted |=> halted)
		else $error("halted dropped without reset");

endmodule

bind cpu_system cpu_system_chk i_chk (
	.clock        (clock),
	.reset        (reset),
	.valid        (bus.valid),
	.ready        (bus.ready),
	.copy_done    (copy_done),
	.watch_strobe (watch_strobe),
	.halted       (halted)
);

// File: test/cpu_system_tb.sv
// ------------------------------
// directed tests of cpu_system running the image in rtl/program.hex
// outputs sampled 1 ns after the falling edge, inputs driven 1 ns after the rising edge
// ------------------------------
`timescale 1ns/1ps

module cpu_system_tb;

	localparam int RESET_CYCLES = 16;
	localparam int BOOT_LIMIT   = 40;
	localparam int STROBE_LIMIT = 100;
	localparam int HALT_LIMIT   = 30;
	localparam int QUIET_CYCLES = 50;
	// worst case of one run, with one partial and two full runs after the first reset
	localparam int RUN_BOUND = RESET_CYCLES + BOOT_LIMIT + 8 * STROBE_LIMIT
		+ HALT_LIMIT + QUIET_CYCLES;
	localparam int TIMEOUT_CYCLES = 3 * RUN_BOUND;

	// values given by the program image
	localparam int BOOT_WATCH  = 0;
	localparam int START_VALUE = 5;
	localparam int STEP_VALUE  = 1;
	localparam int ADD_VALUE   = 7;

	logic       clock;
	logic       reset;
	logic [7:0] watch;
	logic       watch_strobe;
	logic       running;
	logic       halted;

	int errors = 0;
	int cycle_count = 0;
	// watch values seen with a strobe, oldest first
	logic [7:0] strobe_q[$];

	cpu_system i_dut (
		.clock        (clock),
		.reset        (reset),
		.watch        (watch),
		.watch_strobe (watch_strobe),
		.running      (running),
		.halted       (halted)
	);

	initial begin
		clock = 1'b0;
		reset = 1'b1;
	end

	always #10 clock = ~clock;

	// ------------------------------
	// monitor and timeout
	// ------------------------------
	always @(negedge clock) begin
		if (reset === 1'b0 && watch_strobe === 1'b1) begin
			strobe_q.push_back(watch);
		end
	end

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the DUT stopped making progress", cycle_count);
			stop_run();
		end
	end

	task automatic stop_run();
		$display("Finished with errors");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_problem(input string what);
		$display("%s", what);
		stop_run();
	endtask

	task automatic check_equal(input string test_name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			errors = errors + 1;
			$display("Fail %s: expected %0d, actual %0d", test_name, expected, actual);
			stop_run();
		end
	endtask

	// stable point between two rising edges
	task automatic next_sample();
		@(negedge clock);
		#1;
	endtask

	task automatic check_idle(input string test_name);
		check_equal({test_name, " running"}, 0, running);
		check_equal({test_name, " halted"}, 0, halted);
		check_equal({test_name, " watch_strobe"}, 0, watch_strobe);
		check_equal({test_name, " watch"}, 0, watch);
	endtask

	task automatic hold_reset(input string test_name);
		int i;
		@(posedge clock);
		#1;
		reset = 1'b1;
		for (i = 0; i < RESET_CYCLES; i++) begin
			next_sample();
			// cleared from the first reset edge on
			if (i > 0) begin
				check_idle({test_name, " during reset"});
			end
		end
		@(posedge clock);
		#1;
		reset = 1'b0;
		strobe_q.delete();
		next_sample();
		check_idle({test_name, " after reset"});
	endtask

	task automatic expect_strobe(input string test_name, input int expected);
		int waited;
		logic [7:0] value;
		waited = 0;
		while (strobe_q.size() == 0 && waited < STROBE_LIMIT) begin
			next_sample();
			waited = waited + 1;
		end
		if (strobe_q.size() == 0) begin
			report_problem($sformatf("%s: no watch strobe within %0d cycles",
				test_name, STROBE_LIMIT));
		end else begin
			value = strobe_q.pop_front();
			check_equal(test_name, expected, value);
		end
	endtask

	// ------------------------------
	// directed tests
	// ------------------------------
	task automatic reset_state_test();
		hold_reset("reset_state");
	endtask

	task automatic boot_copy_test(input string test_name);
		int waited;
		waited = 0;
		while (running !== 1'b1 && waited < BOOT_LIMIT) begin
			next_sample();
			waited = waited + 1;
		end
		if (running !== 1'b1) begin
			report_problem($sformatf("%s: running did not rise within %0d cycles of reset release",
				test_name, BOOT_LIMIT));
		end else begin
			// the image writes word 31 last, strobe lands with running
			check_equal({test_name, " boot strobes"}, 1, strobe_q.size());
			expect_strobe({test_name, " boot watch"}, BOOT_WATCH);
		end
	endtask

	task automatic countdown_test(input string test_name);
		int value;
		value = START_VALUE;
		expect_strobe(test_name, value);
		while (value != 0) begin
			value = value - STEP_VALUE;
			expect_strobe(test_name, value);
		end
	endtask

	task automatic add_halt_test(input string test_name);
		int waited;
		// acc is 0 after the countdown
		expect_strobe(test_name, ADD_VALUE);
		waited = 0;
		while (halted !== 1'b1 && waited < HALT_LIMIT) begin
			next_sample();
			waited = waited + 1;
		end
		if (halted !== 1'b1) begin
			report_problem($sformatf("%s: halted did not rise within %0d cycles of the last store",
				test_name, HALT_LIMIT));
		end else begin
			repeat (QUIET_CYCLES) next_sample();
			check_equal({test_name, " strobes after halt"}, 0, strobe_q.size());
			check_equal({test_name, " halted"}, 1, halted);
		end
	endtask

	task automatic restart_test();
		hold_reset("restart");
		boot_copy_test("restart");
		expect_strobe("restart", START_VALUE);
		expect_strobe("restart", START_VALUE - STEP_VALUE);
		// reset while the countdown runs
		hold_reset("restart mid-run");
		boot_copy_test("restart");
		countdown_test("restart countdown");
		add_halt_test("restart add_halt");
	endtask

	initial begin
		reset_state_test();
		boot_copy_test("boot_copy");
		countdown_test("countdown");
		add_halt_test("add_halt");
		restart_test();
		if (errors == 0) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			stop_run();
		end
	end

endmodule

// File: verilog.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/mem_bus_if.sv
rtl/boot_copy.sv
rtl/data_ram.sv
rtl/mem_ctrl.sv
rtl/cpu8.sv
rtl/cpu_system.sv
test/cpu_system_chk.sv
test/cpu_system_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cpu_system testbench with verilator, from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module cpu_system_tb -o cpu_system_sim; then
	echo "build failed"
	exit 1
fi

./obj_dir/cpu_system_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Finished with errors" "$LOG"; then
	echo "FAIL"
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "FAIL: simulation exited with status $status"
	exit 1
fi
echo "PASS"
exit 0

// File: rtl/program.hex
// one hex word per line, addresses 0 to 31
// opcode in bits 7:5, operand in bits 4:0
05 // 0  ldi 5
9F // 1  store 31
7E // 2  loop: sub 30
9F // 3  store 31
C6 // 4  jz 6
A2 // 5  jmp 2
5D // 6  end: add 29
9F // 7  store 31
E0 // 8  halt
00 // 9
00 // 10
00 // 11
00 // 12
00 // 13
00 // 14
00 // 15
00 // 16
00 // 17
00 // 18
00 // 19
00 // 20
00 // 21
00 // 22
00 // 23
00 // 24
00 // 25
00 // 26
00 // 27
00 // 28
07 // 29 add operand
01 // 30 countdown step
00 // 31 watch word
